/* rtl/periph_defs.svh */
/*
 * Address map and sizes of the peripheral subsystem.
 * Region code sits in address bits 11:8, the low byte is the offset
 * inside the region. Offsets are byte addresses of 32-bit words.
 */

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// ----------------------------------------
// Bus and sizes
// ----------------------------------------
`define PERIPH_ADDR_W        12
`define PERIPH_DATA_W        32
`define PERIPH_NUM_TIMERS    4
`define PERIPH_NUM_TARGETS   2

// ----------------------------------------
// Regions
// ----------------------------------------
`define PERIPH_REGION_LSB    8
`define PERIPH_REGION_TIMER  4'h0
`define PERIPH_REGION_IRQ    4'h1

// Timer blocks, one per timer
`define PERIPH_TIMER_STRIDE  16
`define PERIPH_TIMER_CTRL    12'h000
`define PERIPH_TIMER_CMP     12'h004
`define PERIPH_TIMER_CNT     12'h008

// Interrupt controller
`define PERIPH_IRQ_PENDING   12'h000
`define PERIPH_IRQ_ENABLE0   12'h004
`define PERIPH_IRQ_ENABLE1   12'h008

`define PERIPH_ERR_RDATA     32'hDEADBEEF // Returned for unmapped reads

`endif

/* rtl/periph_pkg.sv */
/*
 * Shared types of the peripheral subsystem.
 * Widths come from the defines header.
 */

`default_nettype none

`include "periph_defs.svh"

package periph_pkg;

    // ----------------------------------------
    // Bus words
    // ----------------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] reg_addr_t; // Byte address
    typedef logic [`PERIPH_DATA_W-1:0] reg_data_t;

    // AXI response codes without EXOKAY and DECERR
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // ----------------------------------------
    // Decoded regions
    // ----------------------------------------
    typedef enum logic [1:0] {
        TIMER,
        IRQ,
        NONE    // Unmapped region gets SLVERR
    } region_t;

endpackage

`default_nettype wire

/* rtl/axil_slave_fsm.sv */
/*
 * AXI4-Lite slave front end, one transaction in flight.
 * A write is taken only with AW and W valid together and wins over a
 * pending read. Partial strobes and unmapped regions get SLVERR and
 * write nothing; unmapped reads return the error pattern.
 * Data modules answer combinationally in the strobe cycle.
 */

`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module axil_slave_fsm (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // AXI4-Lite slave
    input  logic                  aw_valid_i,
    input  periph_pkg::reg_addr_t aw_addr_i,
    output logic                  aw_ready_o,
    input  logic                  w_valid_i,
    input  periph_pkg::reg_data_t w_data_i,
    input  logic [3:0]            w_strb_i,
    output logic                  w_ready_o,
    output logic                  b_valid_o,
    output periph_pkg::axi_resp_t b_resp_o,
    input  logic                  b_ready_i,
    input  logic                  ar_valid_i,
    input  periph_pkg::reg_addr_t ar_addr_i,
    output logic                  ar_ready_o,
    output logic                  r_valid_o,
    output periph_pkg::reg_data_t r_data_o,
    output periph_pkg::axi_resp_t r_resp_o,
    input  logic                  r_ready_i,
    // Register strobes
    output logic                  timer_wr_o,
    output logic                  timer_rd_o,
    output logic                  irq_wr_o,
    output logic                  irq_rd_o,
    output periph_pkg::reg_addr_t reg_addr_o,
    output periph_pkg::reg_data_t reg_wdata_o,
    input  periph_pkg::reg_data_t timer_rdata_i,
    input  periph_pkg::reg_data_t irq_rdata_i
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_t;

    state_t                state_q;
    logic                  idle;
    logic                  wr_go;
    logic                  rd_go;
    logic                  strb_ok;
    periph_pkg::reg_addr_t sel_addr;
    periph_pkg::region_t   region;
    periph_pkg::reg_data_t rd_data_sel;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    assign idle  = (state_q == IDLE);
    assign wr_go = idle & aw_valid_i & w_valid_i;

    // AW and W are only taken as a pair
    assign aw_ready_o = idle & (~aw_valid_i | w_valid_i);
    assign w_ready_o  = idle & (~w_valid_i | aw_valid_i);
    assign ar_ready_o = idle & ~wr_go; // Write first
    assign rd_go      = ar_valid_i & ar_ready_o;

    assign strb_ok = &w_strb_i;

    // ----------------------------------------
    // Region decode
    // ----------------------------------------
    assign sel_addr = wr_go ? aw_addr_i : ar_addr_i;

    always_comb begin
        case (sel_addr[`PERIPH_ADDR_W-1:`PERIPH_REGION_LSB])
            `PERIPH_REGION_TIMER: region = periph_pkg::TIMER;
            `PERIPH_REGION_IRQ:   region = periph_pkg::IRQ;
            default:              region = periph_pkg::NONE;
        endcase
    end

    always_comb begin
        reg_addr_o = '0;
        reg_addr_o[`PERIPH_REGION_LSB-1:0] = sel_addr[`PERIPH_REGION_LSB-1:0];
    end

    assign reg_wdata_o = w_data_i;

    assign timer_wr_o = wr_go & strb_ok & (region == periph_pkg::TIMER);
    assign irq_wr_o   = wr_go & strb_ok & (region == periph_pkg::IRQ);
    assign timer_rd_o = rd_go & (region == periph_pkg::TIMER);
    assign irq_rd_o   = rd_go & (region == periph_pkg::IRQ);

    always_comb begin
        case (region)
            periph_pkg::TIMER: rd_data_sel = timer_rdata_i;
            periph_pkg::IRQ:   rd_data_sel = irq_rdata_i;
            default:           rd_data_sel = `PERIPH_ERR_RDATA;
        endcase
    end

    // ----------------------------------------
    // State and responses
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_go) state_q <= WRITE_RESP;
                    else if (rd_go) state_q <= READ_RESP;
                end
                WRITE_RESP: if (b_ready_i) state_q <= IDLE;
                READ_RESP:  if (r_ready_i) state_q <= IDLE;
                default:    state_q <= IDLE;
            endcase
        end
    end

    assign b_valid_o = (state_q == WRITE_RESP);
    assign r_valid_o = (state_q == READ_RESP);

    // Payload held until the response handshake
    always_ff @(posedge clk_i) begin
        if (wr_go) begin
            b_resp_o <= (strb_ok && region != periph_pkg::NONE) ? periph_pkg::OKAY
                                                                 : periph_pkg::SLVERR;
        end
        if (rd_go) begin
            r_data_o <= rd_data_sel;
            r_resp_o <= (region != periph_pkg::NONE) ? periph_pkg::OKAY : periph_pkg::SLVERR;
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_timer.sv */
/*
 * Bank of compare-match timers, one 16-byte block each.
 * CTRL bit 0 enables counting, the other CTRL bits read zero.
 * A match restarts CNT from zero and gives a one-cycle irq pulse.
 * A CNT write on the match edge wins over the restart.
 */

`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module periph_timer #(
    parameter int NUM_TIMERS = `PERIPH_NUM_TIMERS
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  periph_pkg::reg_addr_t addr_i,
    input  periph_pkg::reg_data_t wdata_i,
    output periph_pkg::reg_data_t rdata_o,
    output logic [NUM_TIMERS-1:0] timer_irq_o
);

    logic [NUM_TIMERS-1:0] en_q;
    logic [NUM_TIMERS-1:0] match;
    periph_pkg::reg_data_t cmp_q [NUM_TIMERS];
    periph_pkg::reg_data_t cnt_q [NUM_TIMERS];
    periph_pkg::reg_addr_t blk_idx;
    periph_pkg::reg_addr_t blk_off;

    assign blk_idx = addr_i / `PERIPH_TIMER_STRIDE;
    assign blk_off = addr_i % `PERIPH_TIMER_STRIDE;

    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            match[i] = en_q[i] && (cnt_q[i] == cmp_q[i]);
        end
    end

    // ----------------------------------------
    // Counters and register writes
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q        <= '0;
            cmp_q       <= '{default: '0};
            cnt_q       <= '{default: '0};
            timer_irq_o <= '0;
        end else begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                timer_irq_o[i] <= match[i];
                if (match[i]) cnt_q[i] <= '0;
                else if (en_q[i]) cnt_q[i] <= cnt_q[i] + 1'b1;

                if (wr_i && blk_idx == periph_pkg::reg_addr_t'(i)) begin
                    case (blk_off)
                        `PERIPH_TIMER_CTRL: en_q[i]  <= wdata_i[0];
                        `PERIPH_TIMER_CMP:  cmp_q[i] <= wdata_i;
                        `PERIPH_TIMER_CNT:  cnt_q[i] <= wdata_i; // Software reload
                        default: ;
                    endcase
                end
            end
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (blk_idx == periph_pkg::reg_addr_t'(i)) begin
                    case (blk_off)
                        `PERIPH_TIMER_CTRL: rdata_o[0] = en_q[i];
                        `PERIPH_TIMER_CMP:  rdata_o    = cmp_q[i];
                        `PERIPH_TIMER_CNT:  rdata_o    = cnt_q[i];
                        default:            rdata_o    = '0;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/irq_ctrl.sv */
/*
 * Level interrupt controller for up to 32 sources.
 * Source pulses latch into PENDING, writing 1 clears a bit and a
 * new pulse in the same cycle wins. One ENABLE mask per target,
 * target lines are registered.
 */

`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module irq_ctrl #(
    parameter int NUM_SOURCES = `PERIPH_NUM_TIMERS
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          wr_i,
    input  logic                          rd_i,
    input  periph_pkg::reg_addr_t         addr_i,
    input  periph_pkg::reg_data_t         wdata_i,
    output periph_pkg::reg_data_t         rdata_o,
    input  logic [NUM_SOURCES-1:0]        irq_src_i,
    output logic [`PERIPH_NUM_TARGETS-1:0] irq_o
);

    localparam int ENABLE_STRIDE = `PERIPH_IRQ_ENABLE1 - `PERIPH_IRQ_ENABLE0;

    logic [NUM_SOURCES-1:0] pending_q;
    logic [NUM_SOURCES-1:0] clr_mask;
    logic [NUM_SOURCES-1:0] enable_q [`PERIPH_NUM_TARGETS];

    assign clr_mask = (wr_i && addr_i == `PERIPH_IRQ_PENDING) ? wdata_i[NUM_SOURCES-1:0] : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            enable_q  <= '{default: '0};
            irq_o     <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask) | irq_src_i;
            for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
                irq_o[t] <= |(pending_q & enable_q[t]);
                if (wr_i && addr_i == `PERIPH_IRQ_ENABLE0 + t * ENABLE_STRIDE) begin
                    enable_q[t] <= wdata_i[NUM_SOURCES-1:0];
                end
            end
        end
    end

    // Unknown offsets read zero
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            if (addr_i == `PERIPH_IRQ_PENDING) rdata_o[NUM_SOURCES-1:0] = pending_q;
            for (int t = 0; t < `PERIPH_NUM_TARGETS; t++) begin
                if (addr_i == `PERIPH_IRQ_ENABLE0 + t * ENABLE_STRIDE) begin
                    rdata_o[NUM_SOURCES-1:0] = enable_q[t];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_subsystem.sv */
/*
 * Peripheral subsystem top with one AXI4-Lite slave port.
 * Region 0 holds the timer bank, region 1 the interrupt controller.
 * Single clock domain, asynchronous active-low reset.
 */

`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module periph_subsystem (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           aw_valid_i,
    input  periph_pkg::reg_addr_t          aw_addr_i,
    output logic                           aw_ready_o,
    input  logic                           w_valid_i,
    input  periph_pkg::reg_data_t          w_data_i,
    input  logic [3:0]                     w_strb_i,
    output logic                           w_ready_o,
    output logic                           b_valid_o,
    output periph_pkg::axi_resp_t          b_resp_o,
    input  logic                           b_ready_i,
    input  logic                           ar_valid_i,
    input  periph_pkg::reg_addr_t          ar_addr_i,
    output logic                           ar_ready_o,
    output logic                           r_valid_o,
    output periph_pkg::reg_data_t          r_data_o,
    output periph_pkg::axi_resp_t          r_resp_o,
    input  logic                           r_ready_i,
    output logic [`PERIPH_NUM_TARGETS-1:0] irq_o
);

    logic                           timer_wr;
    logic                           timer_rd;
    logic                           irq_wr;
    logic                           irq_rd;
    periph_pkg::reg_addr_t          reg_addr;
    periph_pkg::reg_data_t          reg_wdata;
    periph_pkg::reg_data_t          timer_rdata;
    periph_pkg::reg_data_t          irq_rdata;
    logic [`PERIPH_NUM_TIMERS-1:0]  timer_irq; // One source per timer

    axil_slave_fsm i_axil_slave_fsm (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .aw_valid_i    ( aw_valid_i  ),
        .aw_addr_i     ( aw_addr_i   ),
        .aw_ready_o    ( aw_ready_o  ),
        .w_valid_i     ( w_valid_i   ),
        .w_data_i      ( w_data_i    ),
        .w_strb_i      ( w_strb_i    ),
        .w_ready_o     ( w_ready_o   ),
        .b_valid_o     ( b_valid_o   ),
        .b_resp_o      ( b_resp_o    ),
        .b_ready_i     ( b_ready_i   ),
        .ar_valid_i    ( ar_valid_i  ),
        .ar_addr_i     ( ar_addr_i   ),
        .ar_ready_o    ( ar_ready_o  ),
        .r_valid_o     ( r_valid_o   ),
        .r_data_o      ( r_data_o    ),
        .r_resp_o      ( r_resp_o    ),
        .r_ready_i     ( r_ready_i   ),
        .timer_wr_o    ( timer_wr    ),
        .timer_rd_o    ( timer_rd    ),
        .irq_wr_o      ( irq_wr      ),
        .irq_rd_o      ( irq_rd      ),
        .reg_addr_o    ( reg_addr    ),
        .reg_wdata_o   ( reg_wdata   ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   )
    );

    periph_timer #(
        .NUM_TIMERS ( `PERIPH_NUM_TIMERS )
    ) i_periph_timer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .wr_i        ( timer_wr    ),
        .rd_i        ( timer_rd    ),
        .addr_i      ( reg_addr    ),
        .wdata_i     ( reg_wdata   ),
        .rdata_o     ( timer_rdata ),
        .timer_irq_o ( timer_irq   )
    );

    irq_ctrl #(
        .NUM_SOURCES ( `PERIPH_NUM_TIMERS )
    ) i_irq_ctrl (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .wr_i      ( irq_wr    ),
        .rd_i      ( irq_rd    ),
        .addr_i    ( reg_addr  ),
        .wdata_i   ( reg_wdata ),
        .rdata_o   ( irq_rdata ),
        .irq_src_i ( timer_irq ),
        .irq_o     ( irq_o     )
    );

endmodule

`default_nettype wire

/* verification/tb_periph_subsystem.sv */
/*
 * Testbench for the peripheral subsystem, acting as AXI4-Lite master.
 * Register accesses come from a table and each response is held off
 * by a random delay. Expects 4 timers and the address map of the defines.
 */

`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module tb_periph_subsystem;

    localparam int TIMEOUT = 500;

    typedef struct {
        bit                    is_wr;
        periph_pkg::reg_addr_t addr;
        periph_pkg::reg_data_t wdata;
        logic [3:0]            strb;
        periph_pkg::reg_data_t exp_data;
        periph_pkg::axi_resp_t exp_resp;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           aw_valid;
    periph_pkg::reg_addr_t          aw_addr;
    logic                           aw_ready;
    logic                           w_valid;
    periph_pkg::reg_data_t          w_data;
    logic [3:0]                     w_strb;
    logic                           w_ready;
    logic                           b_valid;
    periph_pkg::axi_resp_t          b_resp;
    logic                           b_ready;
    logic                           ar_valid;
    periph_pkg::reg_addr_t          ar_addr;
    logic                           ar_ready;
    logic                           r_valid;
    periph_pkg::reg_data_t          r_data;
    periph_pkg::axi_resp_t          r_resp;
    logic                           r_ready;
    logic [`PERIPH_NUM_TARGETS-1:0] irq_o;

    row_t   rows [$];
    integer seed;
    integer errors;
    integer tests;
    integer failed;
    bit     irq1_reported;

    periph_subsystem i_dut (
        .clk_i      ( clk      ),
        .rst_n_i    ( rst_n    ),
        .aw_valid_i ( aw_valid ),
        .aw_addr_i  ( aw_addr  ),
        .aw_ready_o ( aw_ready ),
        .w_valid_i  ( w_valid  ),
        .w_data_i   ( w_data   ),
        .w_strb_i   ( w_strb   ),
        .w_ready_o  ( w_ready  ),
        .b_valid_o  ( b_valid  ),
        .b_resp_o   ( b_resp   ),
        .b_ready_i  ( b_ready  ),
        .ar_valid_i ( ar_valid ),
        .ar_addr_i  ( ar_addr  ),
        .ar_ready_o ( ar_ready ),
        .r_valid_o  ( r_valid  ),
        .r_data_o   ( r_data   ),
        .r_resp_o   ( r_resp   ),
        .r_ready_i  ( r_ready  ),
        .irq_o      ( irq_o    )
    );

    always #10 clk = ~clk;

    // Target 1 never gets an enabled source
    always @(negedge clk) begin
        if (rst_n && irq_o[1] !== 1'b0 && !irq1_reported) begin
            $display("** Error irq_o[1] expected 0 got %h", irq_o[1]);
            errors = errors + 1;
            irq1_reported = 1'b1;
        end
    end

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic void add_row(input bit is_wr, input periph_pkg::reg_addr_t addr,
                                    input periph_pkg::reg_data_t wdata, input logic [3:0] strb,
                                    input periph_pkg::reg_data_t exp_data,
                                    input periph_pkg::axi_resp_t exp_resp);
        row_t r;
        r.is_wr    = is_wr;
        r.addr     = addr;
        r.wdata    = wdata;
        r.strb     = strb;
        r.exp_data = exp_data;
        r.exp_resp = exp_resp;
        rows.push_back(r);
    endfunction

    // Response held valid and stable with all request readies low
    task automatic check_pending(input bit is_wr, input periph_pkg::reg_data_t data,
                                 input periph_pkg::axi_resp_t resp);
        logic                  vld;
        periph_pkg::axi_resp_t got;
        vld = is_wr ? b_valid : r_valid;
        got = is_wr ? b_resp : r_resp;
        if (vld !== 1'b1) begin
            $display("** Error %s expected 1 got %h", is_wr ? "b_valid_o" : "r_valid_o", vld);
            errors++;
        end
        if (got !== resp) begin
            $display("** Error %s changed, expected %h got %h",
                     is_wr ? "b_resp_o" : "r_resp_o", resp, got);
            errors++;
        end
        if (!is_wr && r_data !== data) begin
            $display("** Error r_data_o changed, expected %h got %h", data, r_data);
            errors++;
        end
        if (aw_ready !== 1'b0) begin
            $display("** Error aw_ready_o expected 0 got %h", aw_ready);
            errors++;
        end
        if (w_ready !== 1'b0) begin
            $display("** Error w_ready_o expected 0 got %h", w_ready);
            errors++;
        end
        if (ar_ready !== 1'b0) begin
            $display("** Error ar_ready_o expected 0 got %h", ar_ready);
            errors++;
        end
    endtask

    // Called at the negedge after the request handshake edge
    task automatic finish_response(input bit is_wr, output periph_pkg::reg_data_t data,
                                   output periph_pkg::axi_resp_t resp);
        integer delay;
        data  = r_data;
        resp  = is_wr ? b_resp : r_resp;
        delay = $unsigned($random(seed)) % 4;
        check_pending(is_wr, data, resp);
        repeat (delay) begin
            @(negedge clk);
            check_pending(is_wr, data, resp);
        end
        @(posedge clk);
        if (is_wr) b_ready <= 1'b1;
        else r_ready <= 1'b1;
        @(negedge clk);
        check_pending(is_wr, data, resp);   // Last cycle before the handshake
        @(posedge clk);
        b_ready <= 1'b0;
        r_ready <= 1'b0;
        @(negedge clk);
        if (aw_ready !== 1'b1 || w_ready !== 1'b1 || ar_ready !== 1'b1) begin
            $display("** Error aw_ready_o/w_ready_o/ar_ready_o expected 1/1/1 got %h/%h/%h",
                     aw_ready, w_ready, ar_ready);
            errors++;
        end
    endtask

    task automatic axil_access(input row_t r, output periph_pkg::reg_data_t data,
                               output periph_pkg::axi_resp_t resp);
        integer n;
        @(posedge clk);
        if (r.is_wr) begin
            aw_valid <= 1'b1;
            aw_addr  <= r.addr;
            w_valid  <= 1'b1;
            w_data   <= r.wdata;
            w_strb   <= r.strb;
        end else begin
            ar_valid <= 1'b1;
            ar_addr  <= r.addr;
        end
        n = 0;
        @(negedge clk);
        while (r.is_wr ? !(aw_ready && w_ready) : !ar_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("request handshake never happened");
            @(negedge clk);
        end
        if (b_valid !== 1'b0 || r_valid !== 1'b0) begin
            $display("** Error b_valid_o/r_valid_o early, expected 0/0 got %h/%h",
                     b_valid, r_valid);
            errors++;
        end
        @(posedge clk);                 // Handshake edge
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        ar_valid <= 1'b0;
        @(negedge clk);
        finish_response(r.is_wr, data, resp);
    endtask

    task automatic apply_rows();
        periph_pkg::reg_data_t data;
        periph_pkg::axi_resp_t resp;
        integer                err0;
        foreach (rows[i]) begin
            err0 = errors;
            axil_access(rows[i], data, resp);
            if (resp !== rows[i].exp_resp) begin
                $display("** Error %s expected %h got %h",
                         rows[i].is_wr ? "b_resp_o" : "r_resp_o", rows[i].exp_resp, resp);
                errors++;
            end
            if (!rows[i].is_wr && data !== rows[i].exp_data) begin
                $display("** Error r_data_o expected %h got %h", rows[i].exp_data, data);
                errors++;
            end
            end_test($sformatf("%s %h", rows[i].is_wr ? "write" : "read", rows[i].addr), err0);
        end
        rows.delete();
    endtask

    task automatic end_test(input string name, input integer err0);
        tests++;
        if (errors != err0) failed++;
        $display("test %0d %s: %s", tests, name, (errors != err0) ? "FAILED" : "ok");
    endtask

    task automatic wait_irq0(input logic level);
        integer n;
        integer err0;
        err0 = errors;
        n = 0;
        @(negedge clk);
        while (irq_o[0] !== level) begin
            n++;
            if (n > TIMEOUT) abort_run(level ? "irq_o[0] never rose" : "irq_o[0] never fell");
            @(negedge clk);
        end
        end_test(level ? "irq_o[0] rise" : "irq_o[0] fall", err0);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        integer err0;
        clk = 1'b0;
        rst_n = 1'b0;
        aw_valid = 1'b0;
        aw_addr = '0;
        w_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        b_ready = 1'b0;
        ar_valid = 1'b0;
        ar_addr = '0;
        r_ready = 1'b0;
        seed = 83;
        errors = 0;
        tests = 0;
        failed = 0;
        irq1_reported = 1'b0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        err0 = errors;
        if (b_valid !== 1'b0 || r_valid !== 1'b0 || irq_o !== '0) begin
            $display("** Error b_valid_o/r_valid_o/irq_o expected 0/0/0 got %h/%h/%h",
                     b_valid, r_valid, irq_o);
            errors++;
        end
        if (aw_ready !== 1'b1 || w_ready !== 1'b1 || ar_ready !== 1'b1) begin
            $display("** Error aw_ready_o/w_ready_o/ar_ready_o expected 1/1/1 got %h/%h/%h",
                     aw_ready, w_ready, ar_ready);
            errors++;
        end
        end_test("reset outputs", err0);

        // Reset values with the irq region at 0x1xx
        add_row(0, 12'h100, 0, 4'hF, 32'h0, periph_pkg::OKAY);
        add_row(0, 12'h104, 0, 4'hF, 32'h0, periph_pkg::OKAY);
        add_row(0, 12'h108, 0, 4'hF, 32'h0, periph_pkg::OKAY);
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            add_row(0, 12'(i * 16), 0, 4'hF, 32'h0, periph_pkg::OKAY);
            add_row(0, 12'(i * 16 + 4), 0, 4'hF, 32'h0, periph_pkg::OKAY);
        end
        // Readback with CMP far out of reach while enabled
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            add_row(1, 12'(i * 16 + 4), 32'hA5A5_0000 + i, 4'hF, 0, periph_pkg::OKAY);
            add_row(1, 12'(i * 16), 32'h1, 4'hF, 0, periph_pkg::OKAY);
            add_row(0, 12'(i * 16 + 4), 0, 4'hF, 32'hA5A5_0000 + i, periph_pkg::OKAY);
            add_row(0, 12'(i * 16), 0, 4'hF, 32'h1, periph_pkg::OKAY);
            add_row(1, 12'(i * 16), 32'h0, 4'hF, 0, periph_pkg::OKAY);
        end
        add_row(1, 12'h104, 32'h5, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h108, 32'hA, 4'hF, 0, periph_pkg::OKAY);
        add_row(0, 12'h104, 0, 4'hF, 32'h5, periph_pkg::OKAY);
        add_row(0, 12'h108, 0, 4'hF, 32'hA, periph_pkg::OKAY);
        add_row(0, 12'h00C, 0, 4'hF, 32'h0, periph_pkg::OKAY);   // Unknown offsets
        add_row(0, 12'h10C, 0, 4'hF, 32'h0, periph_pkg::OKAY);
        // Error responses
        add_row(0, 12'h200, 0, 4'hF, 32'hDEADBEEF, periph_pkg::SLVERR);
        add_row(0, 12'hF04, 0, 4'hF, 32'hDEADBEEF, periph_pkg::SLVERR);
        add_row(1, 12'h300, 32'h1, 4'hF, 0, periph_pkg::SLVERR);
        add_row(1, 12'h014, 32'h1234_5678, 4'h3, 0, periph_pkg::SLVERR);
        add_row(0, 12'h014, 0, 4'hF, 32'hA5A5_0001, periph_pkg::OKAY);
        // Timer 2 routed to target 0 only
        add_row(1, 12'h024, 32'd20, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h028, 32'h0, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h104, 32'h4, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h108, 32'h0, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h020, 32'h1, 4'hF, 0, periph_pkg::OKAY);
        apply_rows();

        wait_irq0(1'b1);
        add_row(0, 12'h100, 0, 4'hF, 32'h4, periph_pkg::OKAY);
        add_row(1, 12'h020, 32'h0, 4'hF, 0, periph_pkg::OKAY);
        add_row(1, 12'h100, 32'h4, 4'hF, 0, periph_pkg::OKAY);    // Clear pending bit 2
        apply_rows();
        wait_irq0(1'b0);
        add_row(0, 12'h100, 0, 4'hF, 32'h0, periph_pkg::OKAY);
        apply_rows();

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/periph_pkg.sv
rtl/axil_slave_fsm.sv
rtl/periph_timer.sv
rtl/irq_ctrl.sv
rtl/periph_subsystem.sv
verification/tb_periph_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module tb_periph_subsystem -Mdir obj_dir

out=$(./obj_dir/Vtb_periph_subsystem)
echo "$out"

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
else
    exit 1
fi
